//--- quickq_consts.svh
`ifndef QUICKQ_CONSTS_SVH
`define QUICKQ_CONSTS_SVH

////////////////////////////////////////////////////////////
// Entry word layout
////////////////////////////////////////////////////////////

// Priority field width, lower value leaves first
`define QQ_PRIO_W 8
// Payload tag carried along with the priority
`define QQ_TAG_W 8
// Full entry word as stored in the RAM
`define QQ_W (`QQ_PRIO_W + `QQ_TAG_W)

////////////////////////////////////////////////////////////
// Queue geometry
////////////////////////////////////////////////////////////

// Capacity in entries
`define QQ_DEPTH 16
// RAM address width
`define QQ_AW 4
// Count width, one bit wider than the address
`define QQ_CW 5

`endif

//--- quickq_ctrl_pkg.sv
package quickq_ctrl_pkg;

   // Router modes issued by the controller
   typedef enum logic [2:0] {
      // Router passes nothing
      VR_IDLE        = 3'd0,
      // Carry against stored entry, keep the smaller
      VR_ENQ_COMPARE = 3'd1,
      // Carry goes into the first empty slot
      VR_ENQ_TAIL    = 3'd2,
      // Entry 0 out as dequeue result
      VR_DEQ_HEAD    = 3'd3,
      // Stored entry moves down one index
      VR_DEQ_SHIFT   = 3'd4
   } vr_mode_t;

   // Last completed operation
   typedef enum logic [1:0] {
      LO_NONE = 2'b00,
      LO_ENQ  = 2'b01,
      LO_DEQ  = 2'b10
   } last_op_t;

endpackage

//--- quickq_data_pkg.sv
`include "quickq_consts.svh"

package quickq_data_pkg;

   ////////////////////////////////////////////////////////////
   // Entry decoding
   ////////////////////////////////////////////////////////////

   // Priority sits in the upper bits
   typedef struct packed {
      logic [`QQ_PRIO_W-1:0] prio;
      logic [`QQ_TAG_W-1:0]  tag;
   } qq_entry_t;

   // Same word, seen raw or as fields
   typedef union packed {
      // RAM and port view
      logic [`QQ_W-1:0] raw;
      // Compare view
      qq_entry_t        f;
   } qq_word_u;

   // Ordering is by priority only, tag never compared
   function automatic logic prio_lt(qq_word_u a, qq_word_u b);
      return a.f.prio < b.f.prio;
   endfunction

endpackage

//--- quickq_bram.sv
`timescale 1ns/100ps

`include "quickq_consts.svh"

module quickq_bram (
   input  logic             clk_i,
   input  logic             we_i,
   input  logic [`QQ_AW-1:0] addr_i,
   input  logic [`QQ_W-1:0]  wdata_i,
   output logic [`QQ_W-1:0]  rdata_o
);

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // Sorted entries, index 0 holds the head
   logic [`QQ_W-1:0] mem [`QQ_DEPTH];

   // Registered read data
   logic [`QQ_W-1:0] rdata_q;

   // Single port, read-first
   always_ff @(posedge clk_i) begin
      // Old word appears on the read side
      rdata_q <= mem[addr_i];
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

   // One cycle after the address
   assign rdata_o = rdata_q;

endmodule

//--- quickq_value_router.sv
`timescale 1ns/100ps

`include "quickq_consts.svh"

module quickq_value_router (
   input  quickq_ctrl_pkg::vr_mode_t mode_i,
   input  logic [`QQ_W-1:0]          bram_out_i,
   input  logic [`QQ_W-1:0]          carry_i,
   output logic [`QQ_W-1:0]          bram_insert_o,
   output logic [`QQ_W-1:0]          carry_next_o,
   output logic                      swap_o,
   output logic [`QQ_W-1:0]          head_o
);

   import quickq_ctrl_pkg::*;
   import quickq_data_pkg::*;

   // Stored word and carried word in field view
   qq_word_u stored_u;
   qq_word_u carry_u;
   // Carry strictly ahead of the stored entry
   logic     carry_wins;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      stored_u.raw = bram_out_i;
      carry_u.raw  = carry_i;
      // Strict compare keeps equal priorities in arrival order
      carry_wins   = prio_lt(carry_u, stored_u);
   end

   ////////////////////////////////////////////////////////////
   // Route
   ////////////////////////////////////////////////////////////

   always_comb begin
      // Defaults hold the carry and write nothing useful
      bram_insert_o = '0;
      carry_next_o  = carry_i;
      swap_o        = 1'b0;
      head_o        = '0;

      case (mode_i)
         VR_ENQ_COMPARE: begin
            swap_o = carry_wins;
            if (carry_wins) begin
               // Carry takes the slot
               bram_insert_o = carry_u.raw;
               // Displaced entry walks on
               carry_next_o  = stored_u.raw;
            end else begin
               // Slot unchanged
               bram_insert_o = stored_u.raw;
               carry_next_o  = carry_u.raw;
            end
         end

         VR_ENQ_TAIL: begin
            // Largest value so far fills the tail
            bram_insert_o = carry_i;
         end

         VR_DEQ_HEAD: begin
            // Entry 0 as read
            head_o = bram_out_i;
         end

         VR_DEQ_SHIFT: begin
            // Word at i rewritten at i-1
            bram_insert_o = bram_out_i;
         end

         default: begin
            // VR_IDLE
            bram_insert_o = '0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // No swap request from any other mode
   always_comb begin
      if (mode_i != VR_ENQ_COMPARE) begin
         a_swap_mode: assert (!swap_o)
            else $error("quickq_value_router swap outside compare");
      end
   end

   // Walking value never ahead of what stays behind
   always_comb begin
      qq_word_u ins_u;
      qq_word_u nxt_u;
      ins_u.raw = bram_insert_o;
      nxt_u.raw = carry_next_o;
      if (mode_i == VR_ENQ_COMPARE) begin
         a_order_kept: assert (!prio_lt(nxt_u, ins_u))
            else $error("quickq_value_router carry below inserted entry");
      end
   end

endmodule

//--- quickq_ctrl.sv
`timescale 1ns/100ps

`include "quickq_consts.svh"

module quickq_ctrl (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      enq_i,
   input  logic                      deq_i,
   input  logic [`QQ_W-1:0]          data_i,
   input  logic [`QQ_W-1:0]          ram_rdata_i,
   input  logic [`QQ_W-1:0]          bram_insert_i,
   input  logic [`QQ_W-1:0]          carry_next_i,
   input  logic [`QQ_W-1:0]          head_i,
   output logic [`QQ_AW-1:0]         ram_addr_o,
   output logic                      ram_we_o,
   output logic [`QQ_W-1:0]          ram_wdata_o,
   output quickq_ctrl_pkg::vr_mode_t mode_o,
   output logic [`QQ_W-1:0]          carry_o,
   output logic                      ready_o,
   output logic                      done_o,
   output logic [`QQ_W-1:0]          data_o,
   output logic [`QQ_CW-1:0]         count_o,
   output logic                      full_o,
   output logic                      empty_o
);

   import quickq_ctrl_pkg::*;

   typedef enum logic [3:0] {
      ST_IDLE, ST_ENQ_RD, ST_ENQ_CMP, ST_TAIL,
      ST_DEQ_RD, ST_HEAD, ST_SH_RD, ST_SH_WR, ST_DONE
   } state_t;

   state_t            state_q, state_d;
   logic [`QQ_AW-1:0] idx_q, idx_d;
   logic [`QQ_CW-1:0] count_q;
   // Index of the last stored entry
   logic [`QQ_CW-1:0] cnt_m1;
   logic              at_last;
   logic              full_q, empty_q;
   last_op_t          last_op_q;
   logic [`QQ_W-1:0]  carry_q;
   logic [`QQ_W-1:0]  data_q;
   logic              enq_acc, deq_acc, finish;
   // Carry holds a displaced entry, rest of the walk only shifts
   logic              shift_on_q;

   ////////////////////////////////////////////////////////////
   // Command acceptance
   ////////////////////////////////////////////////////////////

   // Enqueue wins a tie
   assign enq_acc = (state_q == ST_IDLE) && enq_i && !full_q;
   assign deq_acc = (state_q == ST_IDLE) && deq_i && !enq_i && !empty_q;

   assign cnt_m1  = count_q - 1'b1;
   assign at_last = (idx_q == cnt_m1[`QQ_AW-1:0]);
   // Operation ends on this edge
   assign finish  = (state_d == ST_DONE);

   // Next state and walk index
   always_comb begin
      state_d = state_q;
      idx_d   = idx_q;
      case (state_q)
         ST_IDLE: begin
            if (enq_acc) begin
               idx_d   = '0;
               // Empty queue goes straight to the tail write
               state_d = empty_q ? ST_TAIL : ST_ENQ_RD;
            end else if (deq_acc) begin
               idx_d   = '0;
               state_d = ST_DEQ_RD;
            end
         end
         ST_ENQ_RD:  state_d = ST_ENQ_CMP;
         ST_ENQ_CMP: begin
            // Tail slot is one past the last entry
            idx_d   = idx_q + 1'b1;
            state_d = at_last ? ST_TAIL : ST_ENQ_RD;
         end
         ST_TAIL:    state_d = ST_DONE;
         ST_DEQ_RD:  state_d = ST_HEAD;
         ST_HEAD: begin
            if (at_last) begin
               state_d = ST_DONE;
            end else begin
               idx_d   = `QQ_AW'(1);
               state_d = ST_SH_RD;
            end
         end
         ST_SH_RD:   state_d = ST_SH_WR;
         ST_SH_WR: begin
            if (at_last) begin
               state_d = ST_DONE;
            end else begin
               idx_d   = idx_q + 1'b1;
               state_d = ST_SH_RD;
            end
         end
         default:    state_d = ST_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // State, count and flags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         idx_q      <= '0;
         count_q    <= '0;
         full_q     <= 1'b0;
         empty_q    <= 1'b1;
         last_op_q  <= LO_NONE;
         data_q     <= '0;
         shift_on_q <= 1'b0;
      end else begin
         state_q <= state_d;
         idx_q   <= idx_d;
         // Operation in flight, stays as last op after done
         if (enq_acc) begin
            last_op_q <= LO_ENQ;
         end else if (deq_acc) begin
            last_op_q <= LO_DEQ;
         end
         // First swap hands the stored word to the carry
         if (enq_acc) begin
            shift_on_q <= 1'b0;
         end else if ((state_q == ST_ENQ_CMP) && (carry_next_i != carry_q)) begin
            shift_on_q <= 1'b1;
         end
         if (finish) begin
            case (last_op_q)
               LO_ENQ: begin
                  count_q <= count_q + 1'b1;
                  empty_q <= 1'b0;
                  full_q  <= (count_q == `QQ_CW'(`QQ_DEPTH - 1));
               end
               LO_DEQ: begin
                  count_q <= count_q - 1'b1;
                  full_q  <= 1'b0;
                  empty_q <= (count_q == `QQ_CW'(1));
                  // Single entry finishes from the head state
                  data_q  <= (state_q == ST_HEAD) ? head_i : carry_q;
               end
               default: count_q <= count_q;
            endcase
         end
      end
   end

   // Carry register, also parks the head during shifts
   always_ff @(posedge clk_i) begin
      if (enq_acc) begin
         carry_q <= data_i;
      end else if (state_q == ST_ENQ_CMP) begin
         // Displaced entries move up one slot in their stored order
         carry_q <= shift_on_q ? ram_rdata_i : carry_next_i;
      end else if (state_q == ST_HEAD) begin
         carry_q <= head_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // RAM and router drive
   ////////////////////////////////////////////////////////////

   // Shift write lands one below the read index
   assign ram_addr_o  = (state_q == ST_SH_WR) ? idx_q - 1'b1 : idx_q;
   assign ram_we_o    = (state_q == ST_ENQ_CMP) || (state_q == ST_TAIL) ||
                        (state_q == ST_SH_WR);
   assign ram_wdata_o = bram_insert_i;

   always_comb begin
      case (state_q)
         // After the first swap the carry is written unconditionally
         ST_ENQ_CMP: mode_o = shift_on_q ? VR_ENQ_TAIL : VR_ENQ_COMPARE;
         ST_TAIL:    mode_o = VR_ENQ_TAIL;
         ST_HEAD:    mode_o = VR_DEQ_HEAD;
         ST_SH_WR:   mode_o = VR_DEQ_SHIFT;
         default:    mode_o = VR_IDLE;
      endcase
   end

   assign carry_o = carry_q;
   assign ready_o = (state_q == ST_IDLE);
   assign done_o  = (state_q == ST_DONE);
   assign data_o  = data_q;
   assign count_o = count_q;
   assign full_o  = full_q;
   assign empty_o = empty_q;

   // Count bounded by capacity
   a_count_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) count_q <= `QQ_DEPTH
   ) else $error("quickq_ctrl count above depth");

   // RAM untouched while idle
   a_idle_no_write: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) (state_q == ST_IDLE) |-> !ram_we_o
   ) else $error("quickq_ctrl write while idle");

endmodule

//--- quickq_top.sv
`timescale 1ns/100ps

`include "quickq_consts.svh"

module quickq_top (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              enq_i,
   input  logic              deq_i,
   input  logic [`QQ_W-1:0]  data_i,
   output logic              ready_o,
   output logic              done_o,
   output logic [`QQ_W-1:0]  data_o,
   output logic [`QQ_CW-1:0] count_o,
   output logic              full_o,
   output logic              empty_o
);

   import quickq_ctrl_pkg::*;

   ////////////////////////////////////////////////////////////
   // Internal nets
   ////////////////////////////////////////////////////////////

   // RAM port
   logic [`QQ_AW-1:0] ram_addr;
   logic              ram_we;
   logic [`QQ_W-1:0]  ram_wdata;
   logic [`QQ_W-1:0]  ram_rdata;
   // Router control and results
   vr_mode_t          mode;
   logic [`QQ_W-1:0]  carry;
   logic [`QQ_W-1:0]  bram_insert;
   logic [`QQ_W-1:0]  carry_next;
   logic              swap;
   logic [`QQ_W-1:0]  head;

   quickq_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enq_i         (enq_i),
      .deq_i         (deq_i),
      .data_i        (data_i),
      .ram_rdata_i   (ram_rdata),
      .bram_insert_i (bram_insert),
      .carry_next_i  (carry_next),
      .head_i        (head),
      .ram_addr_o    (ram_addr),
      .ram_we_o      (ram_we),
      .ram_wdata_o   (ram_wdata),
      .mode_o        (mode),
      .carry_o       (carry),
      .ready_o       (ready_o),
      .done_o        (done_o),
      .data_o        (data_o),
      .count_o       (count_o),
      .full_o        (full_o),
      .empty_o       (empty_o)
   );

   quickq_bram u_bram (
      .clk_i   (clk_i),
      .we_i    (ram_we),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata)
   );

   quickq_value_router u_router (
      .mode_i        (mode),
      .bram_out_i    (ram_rdata),
      .carry_i       (carry),
      .bram_insert_o (bram_insert),
      .carry_next_o  (carry_next),
      .swap_o        (swap),
      .head_o        (head)
   );

   // Displaced entry becomes the carry on the next edge
   a_swap_carry: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) swap |=> (carry == $past(ram_rdata))
   ) else $error("quickq_top carry missed displaced entry");

endmodule

//--- tb_quickq.sv
`timescale 1ns/100ps

`include "quickq_consts.svh"

module tb_quickq;

   ////////////////////////////////////////////////////////////
   // Run length
   ////////////////////////////////////////////////////////////

   localparam int clk_period_ns    = 20;
   localparam int reset_cycles     = 4;
   localparam int n_directed       = 6;
   localparam int n_random         = 200;
   // Empty dequeue, directed pairs, fill and drain with two ignored, random mix
   localparam int n_cmds           = 1 + 2 * n_directed + 2 * `QQ_DEPTH + 2 + n_random;
   // Longest walk plus strobe and trailing cycle
   localparam int worst_cmd_cycles = 2 * `QQ_DEPTH + 4;
   localparam int done_limit       = 2 * `QQ_DEPTH + 4;
   localparam int watchdog_ns      =
      3 * (reset_cycles + 1 + n_cmds * worst_cmd_cycles) * clk_period_ns;
   // ready, empty, full, done, count, data right after reset
   localparam logic [`QQ_CW+`QQ_W+3:0] reset_view =
      {4'b1100, {`QQ_CW{1'b0}}, {`QQ_W{1'b0}}};

   // DUT ports
   logic              clk_i;
   logic              rst_n_i;
   logic              enq_i;
   logic              deq_i;
   logic [`QQ_W-1:0]  data_i;
   logic              ready_o;
   logic              done_o;
   logic [`QQ_W-1:0]  data_o;
   logic [`QQ_CW-1:0] count_o;
   logic              full_o;
   logic              empty_o;

   // Reference queue, sorted by priority, ties in arrival order
   logic [`QQ_W-1:0]  model_q[$];
   // Expected results at the next done_o
   logic [`QQ_CW-1:0] exp_count;
   logic [`QQ_W-1:0]  exp_data;
   logic              exp_deq;
   // High while an ignored command must stay silent
   logic              quiet_win;
   logic [`QQ_CW+`QQ_W+3:0] status_view;

   assign status_view = {ready_o, empty_o, full_o, done_o, count_o, data_o};

   quickq_top u_quickq_top (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .enq_i   (enq_i),
      .deq_i   (deq_i),
      .data_i  (data_i),
      .ready_o (ready_o),
      .done_o  (done_o),
      .data_o  (data_o),
      .count_o (count_o),
      .full_o  (full_o),
      .empty_o (empty_o)
   );

   always #(clk_period_ns / 2) clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////
   // Failure exits
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      abort_run($sformatf("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                          $time, sig, exp_v, act_v));
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [`QQ_PRIO_W-1:0] prio_of(input logic [`QQ_W-1:0] word);
      return word[`QQ_W-1 -: `QQ_PRIO_W];
   endfunction

   function automatic logic [`QQ_W-1:0] make_word(input logic [`QQ_PRIO_W-1:0] prio,
                                                  input logic [`QQ_TAG_W-1:0] tag);
      return {prio, tag};
   endfunction

   // New word goes in front of the first strictly larger priority
   function automatic void model_insert(input logic [`QQ_W-1:0] word);
      int pos;
      pos = model_q.size();
      for (int i = 0; i < model_q.size(); i++) begin
         if (prio_of(word) < prio_of(model_q[i])) begin
            pos = i;
            break;
         end
      end
      model_q.insert(pos, word);
   endfunction

   ////////////////////////////////////////////////////////////
   // Command driver
   ////////////////////////////////////////////////////////////

   // Called 2 ns after a rising edge with the DUT idle
   task automatic send_cmd(input logic is_enq, input logic [`QQ_W-1:0] word);
      logic ignored;
      int   waited;
      ignored = is_enq ? (model_q.size() == `QQ_DEPTH) : (model_q.size() == 0);
      if (!ignored) begin
         if (is_enq) begin
            model_insert(word);
         end else begin
            exp_data = model_q.pop_front();
         end
      end
      exp_deq   = !is_enq;
      exp_count = `QQ_CW'(model_q.size());
      quiet_win = ignored;
      enq_i     = is_enq;
      deq_i     = !is_enq;
      data_i    = word;
      @(posedge clk_i);
      #2;
      enq_i = 1'b0;
      deq_i = 1'b0;
      if (ignored) begin
         repeat (4) begin
            @(posedge clk_i);
            #2;
         end
         quiet_win = 1'b0;
      end else begin
         waited = 0;
         while (!done_o) begin
            if (waited > done_limit) begin
               abort_run($sformatf("no done_o within %0d cycles of an accepted command",
                                   done_limit));
            end
            @(posedge clk_i);
            #2;
            waited++;
         end
         // Done cycle gets sampled on this edge
         @(posedge clk_i);
         #2;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_reset_state: assert property (
      @(posedge clk_i) $rose(rst_n_i) |-> status_view == reset_view
   ) else report_mismatch("{ready_o,empty_o,full_o,done_o,count_o,data_o}",
                          32'(reset_view), 32'($sampled(status_view)));

   a_count: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) done_o |-> count_o == exp_count
   ) else report_mismatch("count_o", 32'(exp_count), 32'($sampled(count_o)));

   a_empty: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) done_o |-> empty_o == (exp_count == 0)
   ) else report_mismatch("empty_o", 32'(exp_count == 0), 32'($sampled(empty_o)));

   a_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) done_o |-> full_o == (exp_count == `QQ_DEPTH)
   ) else report_mismatch("full_o", 32'(exp_count == `QQ_DEPTH), 32'($sampled(full_o)));

   // Head value, ties included through the tag
   a_head: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) (done_o && exp_deq) |-> data_o == exp_data
   ) else report_mismatch("data_o", 32'(exp_data), 32'($sampled(data_o)));

   a_ready_back: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) done_o |=> ready_o
   ) else report_mismatch("ready_o", 32'd1, 32'($sampled(ready_o)));

   // Ignored strobe, no pulse and no count change
   a_quiet_done: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) quiet_win |-> !done_o
   ) else report_mismatch("done_o", 32'd0, 32'($sampled(done_o)));

   a_quiet_count: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) quiet_win |-> count_o == exp_count
   ) else report_mismatch("count_o", 32'(exp_count), 32'($sampled(count_o)));

   // Ignored strobe never starts an operation
   a_quiet_ready: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) quiet_win |-> ready_o
   ) else report_mismatch("ready_o", 32'd1, 32'($sampled(ready_o)));

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      #(watchdog_ns);
      abort_run($sformatf("watchdog expired after %0d ns", watchdog_ns));
   end

   initial begin
      logic                do_enq;
      logic [`QQ_TAG_W-1:0] next_tag;
      void'($urandom(32'h983e6329));
      clk_i     = 1'b0;
      rst_n_i   = 1'b0;
      enq_i     = 1'b0;
      deq_i     = 1'b0;
      data_i    = '0;
      exp_count = '0;
      exp_data  = '0;
      exp_deq   = 1'b0;
      quiet_win = 1'b0;
      next_tag  = '0;
      repeat (reset_cycles) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      @(posedge clk_i);
      #2;

      // Nothing to dequeue yet
      send_cmd(1'b0, '0);

      // Equal priorities interleaved with others
      send_cmd(1'b1, make_word(8'd5, 8'h01));
      send_cmd(1'b1, make_word(8'd3, 8'h02));
      send_cmd(1'b1, make_word(8'd5, 8'h03));
      send_cmd(1'b1, make_word(8'd3, 8'h04));
      send_cmd(1'b1, make_word(8'd9, 8'h05));
      send_cmd(1'b1, make_word(8'd0, 8'h06));
      repeat (n_directed) send_cmd(1'b0, '0);

      // Fill to capacity, one too many, then drain past empty
      repeat (`QQ_DEPTH) begin
         send_cmd(1'b1, make_word(`QQ_PRIO_W'($urandom_range(7, 0)), next_tag));
         next_tag++;
      end
      send_cmd(1'b1, make_word(8'd1, 8'hee));
      repeat (`QQ_DEPTH) send_cmd(1'b0, '0);
      send_cmd(1'b0, '0);

      // Random mix, narrow priority range for frequent ties
      for (int n = 0; n < n_random; n++) begin
         if (model_q.size() == 0) begin
            do_enq = 1'b1;
         end else if (model_q.size() == `QQ_DEPTH) begin
            do_enq = 1'b0;
         end else begin
            do_enq = 1'($urandom_range(1, 0));
         end
         send_cmd(do_enq, make_word(`QQ_PRIO_W'($urandom_range(15, 0)), next_tag));
         next_tag++;
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- src.f
+incdir+.
quickq_ctrl_pkg.sv
quickq_data_pkg.sv
quickq_bram.sv
quickq_value_router.sv
quickq_ctrl.sv
quickq_top.sv
tb_quickq.sv

//--- run.sh
#!/bin/sh
# Build and run the quickq testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_quickq -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_quickq)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q -x -F -- '>>> PASS'; then
   exit 0
fi
echo "Pass line not found in simulation output"
exit 1
